/* tb.f */
rtl/hyper_pkg.sv
rtl/hyper_cmd_if.sv
rtl/hyper_req_stage.sv
rtl/hyper_seq_stage.sv
rtl/hyper_wdata_stage.sv
rtl/hyper_rdata_stage.sv
rtl/hyper_phy_top.sv
verif/hyper_ram_model.sv
verif/hyper_checker.sv
verif/tb_top.sv

/* Makefile */
TOP = tb_top

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* verif/tb_top.sv */
// hyperbus phy testbench top
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import hyper_pkg::*;

    localparam int TIMEOUT = 400;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [7:0]  burst;
        logic        btype;
        logic        force_dbl;
        logic        rwds_lvl;     // model rwds on third command beat
        logic [15:0] seed;
        logic [3:0]  gap;          // cycles between rx credits
    } row_t;

    logic        clk0 = 1'b0;
    logic        rst_ni;
    logic        trans_valid_i, trans_ready_o, trans_write_i, trans_burst_type_i;
    logic [31:0] trans_address_i;
    logic [7:0]  trans_burst_i;
    logic [3:0]  config_t_latency_access_i, config_t_read_write_recovery_i;
    logic        config_en_latency_additional_i;
    logic        tx_valid_i, tx_credit_o, rx_credit_i, rx_valid_o, rx_last_o, b_valid_o;
    logic [15:0] tx_data_i, rx_data_o, hyper_dq_o, hyper_dq_i;
    logic [1:0]  tx_strb_i, hyper_rwds_o;
    logic        hyper_cs_no, hyper_ck_en_o, hyper_dq_oe_o, hyper_rwds_oe_o;
    logic        hyper_reset_no, hyper_rwds_i, rwds_dbl, window_err;

    row_t  rows [8];
    string names [8];
    int    tx_credits = 0;
    int    rx_out = 0;         // rx credits granted but not yet delivered
    int    timeouts = 0;

    always #2 clk0 = ~clk0;

    always @(posedge clk0) begin
        if (rst_ni && tx_credit_o) tx_credits++;
    end

    hyper_phy_top hyper_phy_top_i (.*);

    hyper_ram_model ram (
        .clk0, .rst_ni, .hyper_cs_no, .hyper_ck_en_o, .hyper_dq_o, .hyper_dq_oe_o,
        .hyper_rwds_o, .hyper_rwds_oe_o, .hyper_dq_i, .hyper_rwds_i,
        .lat_i        ( config_t_latency_access_i      ),
        .force_dbl_i  ( config_en_latency_additional_i ),
        .rwds_dbl_i   ( rwds_dbl                       ),
        .window_err_o ( window_err                     )
    );

    hyper_checker chk (
        .clk0, .rst_ni, .hyper_cs_no, .hyper_ck_en_o, .hyper_dq_oe_o, .hyper_dq_o,
        .rx_valid_o, .rx_data_o, .rx_last_o, .b_valid_o, .rx_credit_i, .tx_valid_i,
        .tx_credit_o, .window_err_i ( window_err )
    );

    task automatic run_row(input int r);
        row_t        row;
        logic [47:0] exp_ca;
        logic [1:0]  strb;
        int          widx;
        int          waited;
        logic        done;
        row = rows[r];
        exp_ca        = '0;
        exp_ca[47]    = !row.write;     // read flag, memory space stays zero
        exp_ca[45]    = row.btype;
        exp_ca[44:16] = row.addr[31:3];
        exp_ca[2:0]   = row.addr[2:0];
        chk.start_test(names[r], exp_ca, row.addr[7:0], row.burst, row.write);
        config_en_latency_additional_i = row.force_dbl;
        rwds_dbl = row.rwds_lvl;
        waited = 0;
        while (!trans_ready_o && waited < TIMEOUT) begin
            @(negedge clk0);
            waited++;
        end
        if (!trans_ready_o) begin
            $display("timeout in %s waiting for the request queue", names[r]);
            timeouts++;
        end
        trans_valid_i      = 1'b1;
        trans_write_i      = row.write;
        trans_address_i    = row.addr;
        trans_burst_i      = row.burst;
        trans_burst_type_i = row.btype;
        widx   = 0;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < TIMEOUT) begin
            @(negedge clk0);
            trans_valid_i = 1'b0;
            waited++;
            if (rx_valid_o) rx_out--;
            done = row.write ? b_valid_o : rx_last_o;
            tx_valid_i  = 1'b0;
            rx_credit_i = 1'b0;
            if (row.write && widx <= int'(row.burst) && tx_credits > 0) begin
                strb        = 2'($urandom_range(0, 3));
                tx_valid_i  = 1'b1;
                tx_data_i   = row.seed + 16'(widx);
                tx_strb_i   = strb;
                tx_credits--;
                chk.note_write(8'(row.addr[7:0] + 8'(widx)), row.seed + 16'(widx), strb);
                widx++;
            end
            if (!row.write && rx_out < RX_CREDIT_MAX && waited % int'(row.gap) == 0) begin
                rx_credit_i = 1'b1;
                rx_out++;
            end
        end
        tx_valid_i  = 1'b0;
        rx_credit_i = 1'b0;
        if (!done) begin
            $display("timeout in %s waiting for the end of the burst", names[r]);
            timeouts++;
        end
        @(negedge clk0);
        chk.finish_test();
    endtask

    initial begin
        void'($urandom(32'h6b34_db1a));
        rows[0] = '{1'b0, 32'h10, 8'd3, 1'b0, 1'b0, 1'b0, 16'h0000, 4'd1};
        rows[1] = '{1'b1, 32'h20, 8'd3, 1'b1, 1'b0, 1'b0, 16'h1200, 4'd1};
        rows[2] = '{1'b0, 32'h20, 8'd3, 1'b1, 1'b0, 1'b0, 16'h0000, 4'd1};
        rows[3] = '{1'b1, 32'h43, 8'd1, 1'b0, 1'b0, 1'b1, 16'h3400, 4'd1};
        rows[4] = '{1'b0, 32'h43, 8'd1, 1'b0, 1'b1, 1'b0, 16'h0000, 4'd1};
        rows[5] = '{1'b0, 32'h1e, 8'd5, 1'b0, 1'b0, 1'b0, 16'h0000, 4'd5};
        rows[6] = '{1'b1, 32'h87, 8'd2, 1'b1, 1'b1, 1'b0, 16'h5600, 4'd1};
        rows[7] = '{1'b0, 32'h85, 8'd5, 1'b1, 1'b0, 1'b1, 16'h0000, 4'd3};
        names = '{"rd_unwritten", "wr_mixed_strb", "rd_after_write", "wr_rwds_double",
                  "rd_force_double", "rd_credit_gap", "wr_force_double", "rd_rwds_gap"};
        rst_ni = 1'b0;
        trans_valid_i = 1'b0;
        trans_write_i = 1'b0;
        trans_address_i = '0;
        trans_burst_i = '0;
        trans_burst_type_i = 1'b0;
        config_t_latency_access_i = 4'd3;
        config_t_read_write_recovery_i = 4'd2;
        config_en_latency_additional_i = 1'b0;
        tx_valid_i = 1'b0;
        tx_data_i = '0;
        tx_strb_i = '0;
        rx_credit_i = 1'b0;
        rwds_dbl = 1'b0;
        repeat (3) @(posedge clk0);
        @(negedge clk0);
        chk.check_value("reset hyper_reset_n low", 48'(0), 48'(hyper_reset_no));
        rst_ni = 1'b1;
        chk.check_value("reset cs_n", 48'(1), 48'(hyper_cs_no));
        chk.check_value("reset ck_en", 48'(0), 48'(hyper_ck_en_o));
        chk.check_value("reset dq_oe", 48'(0), 48'(hyper_dq_oe_o));
        chk.check_value("reset rwds_oe", 48'(0), 48'(hyper_rwds_oe_o));
        chk.check_value("reset rx_valid", 48'(0), 48'(rx_valid_o));
        chk.check_value("reset b_valid", 48'(0), 48'(b_valid_o));
        chk.check_value("reset trans_ready", 48'(1), 48'(trans_ready_o));
        for (int r = 0; r < 8; r++) begin
            run_row(r);
        end
        repeat (10) @(negedge clk0);
        chk.check_value("hyper_reset_n released", 48'(1), 48'(hyper_reset_no));
        $display("summary: mismatches %0d, protocol errors %0d, timeouts %0d",
                 chk.mismatch_cnt, chk.proto_cnt, timeouts);
        if (chk.mismatch_cnt + chk.proto_cnt + timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verif/hyper_checker.sv */
// response checker and error counts
module hyper_checker (
    input logic        clk0,
    input logic        rst_ni,
    input logic        hyper_cs_no,
    input logic        hyper_ck_en_o,
    input logic        hyper_dq_oe_o,
    input logic [15:0] hyper_dq_o,
    input logic        rx_valid_o,
    input logic [15:0] rx_data_o,
    input logic        rx_last_o,
    input logic        b_valid_o,
    input logic        rx_credit_i,
    input logic        tx_valid_i,
    input logic        tx_credit_o,
    input logic        window_err_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import hyper_pkg::*;

    int          mismatch_cnt = 0;
    int          proto_cnt = 0;
    string       cur_name = "none";
    logic [47:0] exp_ca;
    logic [47:0] got_ca;
    logic [15:0] ref_mem [256];
    logic [7:0]  base;
    int          len, cmd_beat, rx_idx, b_cnt;
    logic        is_write;
    int          tx_granted = 0;
    int          tx_used = 0;
    int          tx_beats = 0;
    int          rx_granted = 0;
    int          rx_seen = 0;

    initial begin
        for (int a = 0; a < 256; a++) ref_mem[a] = 16'(a) ^ 16'hA5A5;   // unwritten pattern
    end

    task automatic check_value(input string name, input logic [47:0] exp, input logic [47:0] act);
        if (exp !== act) begin
            $display("error %s: expected %h actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("failure in %s: %s", cur_name, msg);
        proto_cnt++;
    endtask

    task automatic start_test(input string name, input logic [47:0] ca, input logic [7:0] a,
                              input logic [7:0] burst, input logic wr);
        cur_name = name;
        exp_ca   = ca;
        base     = a;
        len      = int'(burst) + 1;
        is_write = wr;
        rx_idx   = 0;
        b_cnt    = 0;
    endtask

    task automatic note_write(input logic [7:0] a, input logic [15:0] d, input logic [1:0] s);
        if (s[0]) ref_mem[a][7:0] = d[7:0];
        if (s[1]) ref_mem[a][15:8] = d[15:8];
    endtask

    task automatic finish_test();
        if (is_write) check_value({cur_name, " b_valid count"}, 48'(1), 48'(b_cnt));
        else check_value({cur_name, " rx count"}, 48'(len), 48'(rx_idx));
    endtask

    // dut outputs settle by the falling edge
    always @(negedge clk0) begin
        if (rst_ni) begin
            if (hyper_cs_no) begin
                cmd_beat = 0;
            end else if (hyper_ck_en_o && hyper_dq_oe_o && cmd_beat < 3) begin
                got_ca = {got_ca[31:0], hyper_dq_o};
                cmd_beat++;
                if (cmd_beat == 3) check_value({cur_name, " command word"}, exp_ca, got_ca);
            end else if (hyper_ck_en_o && hyper_dq_oe_o) begin
                tx_beats++;     // write data beat
                if (tx_beats > tx_used) report_failure("write beat sent from an empty buffer");
            end
            if (rx_valid_o) begin
                check_value({cur_name, " rx data"}, 48'(ref_mem[8'(base + 8'(rx_idx))]),
                            48'(rx_data_o));
                check_value({cur_name, " rx last"}, 48'(rx_idx == len - 1), 48'(rx_last_o));
                rx_idx++;
                rx_seen++;
                if (rx_seen > rx_granted) report_failure("rx word delivered without a credit");
            end
            if (b_valid_o) b_cnt++;
            if (tx_credit_o) begin
                tx_granted++;
                if (tx_granted > int'(TX_DEPTH) + tx_beats)
                    report_failure("tx credit issued with no free buffer slot");
            end
            if (window_err_i) report_failure("write beat outside the device data window");
        end
    end

    always @(posedge clk0) begin
        if (rst_ni) begin
            if (rx_credit_i) rx_granted++;
            if (tx_valid_i) tx_used++;
        end
    end

endmodule

/* verif/hyper_ram_model.sv */
// word level hyperram model
module hyper_ram_model (
    input  logic        clk0,
    input  logic        rst_ni,
    input  logic        hyper_cs_no,
    input  logic        hyper_ck_en_o,
    input  logic [15:0] hyper_dq_o,
    input  logic        hyper_dq_oe_o,
    input  logic [1:0]  hyper_rwds_o,
    input  logic        hyper_rwds_oe_o,
    input  logic [3:0]  lat_i,
    input  logic        force_dbl_i,
    input  logic        rwds_dbl_i,
    output logic [15:0] hyper_dq_i,
    output logic        hyper_rwds_i,
    output logic        window_err_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] mem [256];
    logic [47:0] ca_q;
    int          beat_q;
    int          start;
    logic [7:0]  addr;
    logic        in_win;
    logic        is_read;

    initial begin
        for (int a = 0; a < 256; a++) mem[a] = 16'(a) ^ 16'hA5A5;
    end

    always_comb begin
        start   = 3 + ((rwds_dbl_i || force_dbl_i) ? 2 : 1) * int'(lat_i);
        in_win  = !hyper_cs_no && beat_q >= start;
        is_read = ca_q[47];
        addr    = 8'({ca_q[44:16], ca_q[2:0]}) + 8'(beat_q - start);
    end

    // rwds on third command beat asks for double latency
    assign hyper_rwds_i = (!hyper_cs_no && beat_q == 2) ? rwds_dbl_i
                                                         : (in_win && is_read && hyper_ck_en_o);
    assign hyper_dq_i   = (in_win && is_read) ? mem[addr] : 16'hdead;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q       <= 0;
            ca_q         <= '0;
            window_err_o <= 1'b0;
        end else begin
            window_err_o <= hyper_rwds_oe_o && hyper_ck_en_o && !in_win;
            if (hyper_cs_no) begin
                beat_q <= 0;
            end else if (hyper_ck_en_o) begin
                beat_q <= beat_q + 1;
                if (beat_q < 3) ca_q <= {ca_q[31:0], hyper_dq_o};
            end
        end
    end

    always @(posedge clk0) begin
        if (in_win && hyper_dq_oe_o && hyper_rwds_oe_o && hyper_ck_en_o) begin
            if (hyper_rwds_o[0]) mem[addr][7:0] <= hyper_dq_o[7:0];
            if (hyper_rwds_o[1]) mem[addr][15:8] <= hyper_dq_o[15:8];
        end
    end

endmodule

/* rtl/hyper_phy_top.sv */
// hyperbus memory controller phy
module hyper_phy_top (
    input  logic                          clk0,
    input  logic                          rst_ni,
    // transactions
    input  logic                          trans_valid_i,
    output logic                          trans_ready_o,
    input  logic                          trans_write_i,
    input  logic [hyper_pkg::ADDR_W-1:0]  trans_address_i,
    input  logic [hyper_pkg::BURST_W-1:0] trans_burst_i,
    input  logic                          trans_burst_type_i,
    input  logic [hyper_pkg::LAT_W-1:0]   config_t_latency_access_i,
    input  logic                          config_en_latency_additional_i,
    input  logic [hyper_pkg::LAT_W-1:0]   config_t_read_write_recovery_i,
    // transmit, credit based
    input  logic                          tx_valid_i,
    input  logic [hyper_pkg::WORD_W-1:0]  tx_data_i,
    input  logic [hyper_pkg::STRB_W-1:0]  tx_strb_i,
    output logic                          tx_credit_o,
    // receive, credit based
    input  logic                          rx_credit_i,
    output logic                          rx_valid_o,
    output logic [hyper_pkg::WORD_W-1:0]  rx_data_o,
    output logic                          rx_last_o,
    output logic                          b_valid_o,
    // device side
    output logic                          hyper_cs_no,
    output logic                          hyper_ck_en_o,
    output logic [hyper_pkg::WORD_W-1:0]  hyper_dq_o,
    output logic                          hyper_dq_oe_o,
    output logic [hyper_pkg::STRB_W-1:0]  hyper_rwds_o,
    output logic                          hyper_rwds_oe_o,
    output logic                          hyper_reset_no,
    input  logic [hyper_pkg::WORD_W-1:0]  hyper_dq_i,
    input  logic                          hyper_rwds_i
);

    logic                         wr_pop;
    logic                         wr_valid;
    logic                         rd_beat;
    logic                         rd_last;
    logic                         rd_credit_ok;
    logic [hyper_pkg::WORD_W-1:0] ca_beat;

    hyper_cmd_if cmd_if ();

    assign hyper_reset_no = rst_ni;

    hyper_req_stage hyper_req_stage_i (
        .clk0               ( clk0               ),
        .rst_ni             ( rst_ni             ),
        .trans_valid_i      ( trans_valid_i      ),
        .trans_ready_o      ( trans_ready_o      ),
        .trans_write_i      ( trans_write_i      ),
        .trans_address_i    ( trans_address_i    ),
        .trans_burst_i      ( trans_burst_i      ),
        .trans_burst_type_i ( trans_burst_type_i ),
        .cmd_o              ( cmd_if.req_mp      )
    );

    hyper_seq_stage hyper_seq_stage_i (
        .clk0                           ( clk0                           ),
        .rst_ni                         ( rst_ni                         ),
        .cmd_i                          ( cmd_if.seq_mp                  ),
        .config_t_latency_access_i      ( config_t_latency_access_i      ),
        .config_en_latency_additional_i ( config_en_latency_additional_i ),
        .config_t_read_write_recovery_i ( config_t_read_write_recovery_i ),
        .hyper_rwds_i                   ( hyper_rwds_i                   ),
        .wr_valid_i                     ( wr_valid                       ),
        .wr_pop_o                       ( wr_pop                         ),
        .rd_credit_ok_i                 ( rd_credit_ok                   ),
        .rd_beat_o                      ( rd_beat                        ),
        .rd_last_o                      ( rd_last                        ),
        .b_valid_o                      ( b_valid_o                      ),
        .hyper_cs_no                    ( hyper_cs_no                    ),
        .hyper_ck_en_o                  ( hyper_ck_en_o                  ),
        .hyper_dq_oe_o                  ( hyper_dq_oe_o                  ),
        .hyper_rwds_oe_o                ( hyper_rwds_oe_o                ),
        .ca_beat_o                      ( ca_beat                        )
    );

    hyper_wdata_stage hyper_wdata_stage_i (
        .clk0         ( clk0         ),
        .rst_ni       ( rst_ni       ),
        .tx_valid_i   ( tx_valid_i   ),
        .tx_data_i    ( tx_data_i    ),
        .tx_strb_i    ( tx_strb_i    ),
        .tx_credit_o  ( tx_credit_o  ),
        .wr_pop_i     ( wr_pop       ),
        .wr_valid_o   ( wr_valid     ),
        .ca_beat_i    ( ca_beat      ),
        .hyper_dq_o   ( hyper_dq_o   ),
        .hyper_rwds_o ( hyper_rwds_o )
    );

    hyper_rdata_stage hyper_rdata_stage_i (
        .clk0           ( clk0         ),
        .rst_ni         ( rst_ni       ),
        .rx_credit_i    ( rx_credit_i  ),
        .rd_beat_i      ( rd_beat      ),
        .rd_last_i      ( rd_last      ),
        .hyper_dq_i     ( hyper_dq_i   ),
        .rd_credit_ok_o ( rd_credit_ok ),
        .rx_valid_o     ( rx_valid_o   ),
        .rx_data_o      ( rx_data_o    ),
        .rx_last_o      ( rx_last_o    )
    );

endmodule

/* rtl/hyper_rdata_stage.sv */
// read capture and rx credit counter
module hyper_rdata_stage (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  logic                         rx_credit_i,
    input  logic                         rd_beat_i,
    input  logic                         rd_last_i,
    input  logic [hyper_pkg::WORD_W-1:0] hyper_dq_i,
    output logic                         rd_credit_ok_o,
    output logic                         rx_valid_o,
    output logic [hyper_pkg::WORD_W-1:0] rx_data_o,
    output logic                         rx_last_o
);
    import hyper_pkg::*;

    logic [CREDIT_W-1:0] credit_q;

    assign rd_credit_ok_o = (credit_q != '0);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q   <= '0;
            rx_valid_o <= 1'b0;
            rx_last_o  <= 1'b0;
        end else begin
            case ({rx_credit_i, rd_beat_i})
                2'b10: if (credit_q < CREDIT_W'(RX_CREDIT_MAX)) credit_q <= credit_q + 1'b1;
                2'b01: credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;  // none, or grant and use together
            endcase
            rx_valid_o <= rd_beat_i;
            rx_last_o  <= rd_beat_i && rd_last_i;
        end
    end

    always_ff @(posedge clk0) begin
        if (rd_beat_i) rx_data_o <= hyper_dq_i;
    end

    assert property (@(posedge clk0) disable iff (!rst_ni) rd_beat_i |-> credit_q != '0)
        else $error("read beat issued with no rx credit");

endmodule

/* rtl/hyper_wdata_stage.sv */
// write data buffer with tx credits
module hyper_wdata_stage (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  logic                         tx_valid_i,
    input  logic [hyper_pkg::WORD_W-1:0] tx_data_i,
    input  logic [hyper_pkg::STRB_W-1:0] tx_strb_i,
    output logic                         tx_credit_o,
    input  logic                         wr_pop_i,
    output logic                         wr_valid_o,
    input  logic [hyper_pkg::WORD_W-1:0] ca_beat_i,
    output logic [hyper_pkg::WORD_W-1:0] hyper_dq_o,
    output logic [hyper_pkg::STRB_W-1:0] hyper_rwds_o
);
    import hyper_pkg::*;

    logic [WORD_W-1:0]           data_q [TX_DEPTH];
    logic [STRB_W-1:0]           strb_q [TX_DEPTH];
    logic [$clog2(TX_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(TX_DEPTH)-1:0] rd_ptr_q;
    logic [CREDIT_W-1:0]         count_q;
    logic [CREDIT_W-1:0]         owed_q;    // credits not yet sent
    logic                        credit_take;

    assign credit_take = (owed_q != '0);
    assign wr_valid_o  = (count_q != '0);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            owed_q      <= CREDIT_W'(TX_DEPTH);
            tx_credit_o <= 1'b0;
        end else begin
            if (tx_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (wr_pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q     <= count_q + CREDIT_W'(tx_valid_i) - CREDIT_W'(wr_pop_i);
            owed_q      <= owed_q - CREDIT_W'(credit_take) + CREDIT_W'(wr_pop_i);
            tx_credit_o <= credit_take;
        end
    end

    always_ff @(posedge clk0) begin
        if (tx_valid_i) begin
            data_q[wr_ptr_q] <= tx_data_i;
            strb_q[wr_ptr_q] <= tx_strb_i;
        end
    end

    assign hyper_dq_o   = wr_pop_i ? data_q[rd_ptr_q] : ca_beat_i;
    assign hyper_rwds_o = wr_pop_i ? strb_q[rd_ptr_q] : '0;

    assert property (@(posedge clk0) disable iff (!rst_ni)
                     tx_valid_i |-> count_q < CREDIT_W'(TX_DEPTH))
        else $error("tx word pushed without credit, write buffer full");

endmodule

/* rtl/hyper_seq_stage.sv */
// hyperbus bus sequencer
module hyper_seq_stage (
    input  logic                         clk0,
    input  logic                         rst_ni,
    hyper_cmd_if.seq_mp                  cmd_i,
    input  logic [hyper_pkg::LAT_W-1:0]  config_t_latency_access_i,
    input  logic                         config_en_latency_additional_i,
    input  logic [hyper_pkg::LAT_W-1:0]  config_t_read_write_recovery_i,
    input  logic                         hyper_rwds_i,
    input  logic                         wr_valid_i,
    output logic                         wr_pop_o,
    input  logic                         rd_credit_ok_i,
    output logic                         rd_beat_o,
    output logic                         rd_last_o,
    output logic                         b_valid_o,
    output logic                         hyper_cs_no,
    output logic                         hyper_ck_en_o,
    output logic                         hyper_dq_oe_o,
    output logic                         hyper_rwds_oe_o,
    output logic [hyper_pkg::WORD_W-1:0] ca_beat_o
);
    import hyper_pkg::*;

    seq_state_e         state_q;
    seq_state_e         data_state;
    logic [1:0]         cmd_cnt_q;
    logic [LAT_W-1:0]   lat_cnt_q;
    logic [BURST_W-1:0] burst_cnt_q;
    logic [LAT_W-1:0]   rec_cnt_q;
    logic               double_q;
    logic [CA_W-1:0]    ca_q;
    hyper_op_e          op_q;
    logic               data_beat;

    assign cmd_i.cmd_pop = (state_q == IDLE) && cmd_i.cmd_valid;
    assign data_state    = (op_q == OP_WRITE) ? DATA_W : DATA_R;

    assign wr_pop_o  = (state_q == DATA_W) && wr_valid_i;   // stalls on empty buffer
    assign rd_beat_o = (state_q == DATA_R) && rd_credit_ok_i;
    assign rd_last_o = rd_beat_o && (burst_cnt_q == '0);
    assign data_beat = wr_pop_o || rd_beat_o;

    assign hyper_cs_no     = (state_q == IDLE) || (state_q == RECOVER);
    assign hyper_dq_oe_o   = (state_q == CMD) || (state_q == DATA_W);
    assign hyper_rwds_oe_o = (state_q == DATA_W);

    always_comb begin
        case (state_q)
            CMD, LATENCY, LATENCY2: hyper_ck_en_o = 1'b1;
            DATA_W:                 hyper_ck_en_o = wr_valid_i;
            DATA_R:                 hyper_ck_en_o = rd_credit_ok_i;
            default:                hyper_ck_en_o = 1'b0;
        endcase
    end

    // top slice first
    always_comb begin
        ca_beat_o = '0;
        if (state_q == CMD) begin
            case (cmd_cnt_q)
                2'd0:    ca_beat_o = ca_q[CA_W-1 -: WORD_W];
                2'd1:    ca_beat_o = ca_q[CA_W-WORD_W-1 -: WORD_W];
                2'd2:    ca_beat_o = ca_q[WORD_W-1:0];
                default: ca_beat_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk0) begin
        if (cmd_i.cmd_pop) begin
            ca_q <= cmd_i.ca;
            op_q <= cmd_i.op;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            cmd_cnt_q   <= 2'd0;
            lat_cnt_q   <= '0;
            burst_cnt_q <= '0;
            rec_cnt_q   <= '0;
            double_q    <= 1'b0;
            b_valid_o   <= 1'b0;
        end else begin
            b_valid_o <= wr_pop_o && (burst_cnt_q == '0);
            case (state_q)
                IDLE: begin
                    if (cmd_i.cmd_pop) begin
                        state_q     <= CMD;
                        cmd_cnt_q   <= 2'd0;
                        burst_cnt_q <= cmd_i.burst;
                    end
                end
                CMD: begin
                    if (cmd_cnt_q == 2'd2) begin
                        // device asks for double latency on rwds
                        double_q  <= hyper_rwds_i || config_en_latency_additional_i;
                        lat_cnt_q <= config_t_latency_access_i - LAT_W'(1);
                        state_q   <= LATENCY;
                    end else begin
                        cmd_cnt_q <= cmd_cnt_q + 2'd1;
                    end
                end
                LATENCY, LATENCY2: begin
                    if (lat_cnt_q == '0) begin
                        if (state_q == LATENCY && double_q) begin
                            lat_cnt_q <= config_t_latency_access_i - LAT_W'(1);
                            state_q   <= LATENCY2;
                        end else begin
                            state_q <= data_state;
                        end
                    end else begin
                        lat_cnt_q <= lat_cnt_q - LAT_W'(1);
                    end
                end
                DATA_W, DATA_R: begin
                    if (data_beat) begin    // only issued beats count
                        if (burst_cnt_q == '0) begin
                            rec_cnt_q <= config_t_read_write_recovery_i;
                            state_q   <= RECOVER;
                        end else begin
                            burst_cnt_q <= burst_cnt_q - BURST_W'(1);
                        end
                    end
                end
                RECOVER: begin
                    if (rec_cnt_q <= LAT_W'(1)) state_q <= IDLE;
                    else rec_cnt_q <= rec_cnt_q - LAT_W'(1);
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // cs only goes high into recovery, never straight back to idle
    assert property (@(posedge clk0) disable iff (!rst_ni)
                     $rose(hyper_cs_no) |-> state_q == RECOVER)
        else $error("chip select released without a recovery gap");

    assert property (@(posedge clk0) disable iff (!rst_ni) hyper_ck_en_o |-> !hyper_cs_no)
        else $error("bus clock running with chip select high");

endmodule

/* rtl/hyper_req_stage.sv */
// two entry request queue with ca word build
module hyper_req_stage (
    input  logic                          clk0,
    input  logic                          rst_ni,
    input  logic                          trans_valid_i,
    output logic                          trans_ready_o,
    input  logic                          trans_write_i,
    input  logic [hyper_pkg::ADDR_W-1:0]  trans_address_i,
    input  logic [hyper_pkg::BURST_W-1:0] trans_burst_i,
    input  logic                          trans_burst_type_i,
    hyper_cmd_if.req_mp                   cmd_o
);
    import hyper_pkg::*;

    logic [CA_W-1:0]    ca_q    [2];
    hyper_op_e          op_q    [2];
    logic [BURST_W-1:0] burst_q [2];
    logic               wr_ptr_q;
    logic               rd_ptr_q;
    logic [1:0]         count_q;
    logic               push;
    logic [CA_W-1:0]    ca_new;

    // read flag, memory space, burst type, upper and lower address
    assign ca_new = {~trans_write_i, 1'b0, trans_burst_type_i,
                     trans_address_i[ADDR_W-1:3], 13'b0, trans_address_i[2:0]};

    assign trans_ready_o = (count_q != 2'd2);
    assign push          = trans_valid_i && trans_ready_o;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (cmd_o.cmd_pop) rd_ptr_q <= ~rd_ptr_q;
            count_q <= count_q + 2'(push) - 2'(cmd_o.cmd_pop);
        end
    end

    always_ff @(posedge clk0) begin
        if (push) begin
            ca_q[wr_ptr_q]    <= ca_new;
            op_q[wr_ptr_q]    <= trans_write_i ? OP_WRITE : OP_READ;
            burst_q[wr_ptr_q] <= trans_burst_i;
        end
    end

    assign cmd_o.cmd_valid = (count_q != 2'd0);
    assign cmd_o.ca        = ca_q[rd_ptr_q];
    assign cmd_o.op        = op_q[rd_ptr_q];
    assign cmd_o.burst     = burst_q[rd_ptr_q];

    // sequencer must not pop an empty queue
    assert property (@(posedge clk0) disable iff (!rst_ni) cmd_o.cmd_pop |-> count_q != 2'd0)
        else $error("command popped from empty request queue");

endmodule

/* rtl/hyper_cmd_if.sv */
// command handoff from request queue to sequencer
interface hyper_cmd_if;
    import hyper_pkg::*;

    logic               cmd_valid;
    logic               cmd_pop;    // removes head entry
    logic [CA_W-1:0]    ca;
    hyper_op_e          op;
    logic [BURST_W-1:0] burst;

    modport req_mp (
        output cmd_valid,
        output ca,
        output op,
        output burst,
        input  cmd_pop
    );

    modport seq_mp (
        input  cmd_valid,
        input  ca,
        input  op,
        input  burst,
        output cmd_pop
    );

endinterface

/* rtl/hyper_pkg.sv */
// hyperbus phy shared definitions
package hyper_pkg;

    localparam int unsigned ADDR_W        = 32;
    localparam int unsigned WORD_W        = 16;
    localparam int unsigned STRB_W        = 2;
    localparam int unsigned CA_W          = 48;
    localparam int unsigned BURST_W       = 8;  // words minus one
    localparam int unsigned LAT_W         = 4;
    localparam int unsigned TX_DEPTH      = 4;  // also initial tx credits
    localparam int unsigned RX_CREDIT_MAX = 4;
    localparam int unsigned CREDIT_W      = 3;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } hyper_op_e;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        LATENCY,
        LATENCY2,   // second latency window
        DATA_R,
        DATA_W,
        RECOVER
    } seq_state_e;

endpackage
